// ==== Makefile ====
SRCS := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

obj_dir/Vtb_rv_decode: sim.f $(SRCS)
	verilator --binary --timing --top-module tb_rv_decode -f sim.f

run: obj_dir/Vtb_rv_decode
	./obj_dir/Vtb_rv_decode | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== hw/ctrl_gen.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module ctrl_gen
    import rv_decode_pkg::*;
(
    input  instr_kind_e i_kind,
    output logic        o_reg_write,
    output logic        o_mem_read,
    output logic        o_mem_write,
    output logic        o_jump,
    output logic        o_branch,
    output logic        o_pc_sel,
    output logic        o_illegal,
    output op1_sel_e    o_op1_sel,
    output op2_sel_e    o_op2_sel,
    output res_src_e    o_res_src,
    output alu_ctrl_t   o_alu_ctrl
);

    always_comb
    begin
        o_reg_write = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_jump      = 1'b0;
        o_branch    = 1'b0;
        o_pc_sel    = 1'b0;
        o_illegal   = 1'b0;
        o_op1_sel   = OP1_REG;
        o_op2_sel   = OP2_IMM;
        o_res_src   = RES_ALU;
        case (i_kind)
        KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU:
        begin
            o_reg_write = 1'b1;
            o_mem_read  = 1'b1;
            o_res_src   = RES_MEM;
        end
        KIND_SB, KIND_SH, KIND_SW:
            o_mem_write = 1'b1;
        KIND_ADD, KIND_SUB, KIND_SLL, KIND_SLT, KIND_SLTU,
        KIND_XOR, KIND_SRL, KIND_SRA, KIND_OR, KIND_AND:
        begin
            o_reg_write = 1'b1;
            o_op2_sel   = OP2_REG;
        end
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU:
        begin
            o_branch  = 1'b1;
            o_op2_sel = OP2_REG;
        end
        KIND_LUI:
        begin
            o_reg_write = 1'b1;
            o_op1_sel   = OP1_ZERO;
        end
        KIND_AUIPC:
        begin
            o_reg_write = 1'b1;
            o_op1_sel   = OP1_PC;
        end
        KIND_JAL, KIND_JALR:
        begin
            o_reg_write = 1'b1;
            o_jump      = 1'b1;
            o_res_src   = RES_PC4;
            // jal adds to pc, jalr to rs1
            o_op1_sel   = (i_kind == KIND_JAL) ? OP1_PC : OP1_REG;
            o_pc_sel    = (i_kind == KIND_JALR);
        end
        KIND_ILLEGAL:
        begin
            o_illegal = 1'b1;
            o_op2_sel = OP2_REG;
        end
        // remaining kinds are the register-immediate ops
        default:
            o_reg_write = 1'b1;
        endcase
    end

    always_comb
    begin
        o_alu_ctrl.arith = (i_kind == KIND_SRA) || (i_kind == KIND_SRAI);
        case (i_kind)
        KIND_BEQ:                           o_alu_ctrl.op = `RV_ALU_EQ;
        KIND_BNE:                           o_alu_ctrl.op = `RV_ALU_NEQ;
        KIND_BLT, KIND_SLT, KIND_SLTI:      o_alu_ctrl.op = `RV_ALU_LTS;
        KIND_BGE:                           o_alu_ctrl.op = `RV_ALU_NLTS;
        KIND_BLTU, KIND_SLTU, KIND_SLTIU:   o_alu_ctrl.op = `RV_ALU_LTU;
        KIND_BGEU:                          o_alu_ctrl.op = `RV_ALU_NLTU;
        KIND_SUB:                           o_alu_ctrl.op = `RV_ALU_SUB;
        KIND_XOR, KIND_XORI:                o_alu_ctrl.op = `RV_ALU_XOR;
        KIND_OR, KIND_ORI:                  o_alu_ctrl.op = `RV_ALU_OR;
        KIND_AND, KIND_ANDI:                o_alu_ctrl.op = `RV_ALU_AND;
        KIND_SLL, KIND_SLLI:                o_alu_ctrl.op = `RV_ALU_SHL;
        KIND_SRL, KIND_SRLI, KIND_SRA, KIND_SRAI:
                                            o_alu_ctrl.op = `RV_ALU_SHR;
        default:                            o_alu_ctrl.op = `RV_ALU_ADD;
        endcase
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    input  instr_kind_e         i_kind,
    output logic [`RV_XLEN-1:0] o_imm
);

    always_comb
    begin
        case (i_kind)
        KIND_JAL:
            o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
        KIND_LUI, KIND_AUIPC:
            o_imm = {i_instr[31:12], 12'b0};
        KIND_JALR, KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
        KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
        KIND_SLLI, KIND_SRLI, KIND_SRAI:
            o_imm = {{21{i_instr[31]}}, i_instr[30:20]};
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU:
            o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
        KIND_SB, KIND_SH, KIND_SW:
            o_imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
        // register ops and illegal words carry no immediate
        default:
            o_imm = '0;
        endcase
    end

endmodule

// ==== hw/op_classifier.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module op_classifier
    import rv_decode_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    output instr_kind_e         o_kind
);

    logic [4:0] w_opg;
    logic [2:0] w_f3;
    logic [6:0] w_f7;

    assign w_opg = i_instr[6:2];
    assign w_f3  = i_instr[14:12];
    assign w_f7  = i_instr[31:25];

    always_comb
    begin
        o_kind = KIND_ILLEGAL;
        // compressed words never match
        if (i_instr[1:0] == 2'b11)
        begin
            case (w_opg)
            `RV_OPG_LOAD:
                case (w_f3)
                3'b000: o_kind = KIND_LB;
                3'b001: o_kind = KIND_LH;
                3'b010: o_kind = KIND_LW;
                3'b100: o_kind = KIND_LBU;
                3'b101: o_kind = KIND_LHU;
                default: o_kind = KIND_ILLEGAL;
                endcase
            `RV_OPG_STORE:
                case (w_f3)
                3'b000: o_kind = KIND_SB;
                3'b001: o_kind = KIND_SH;
                3'b010: o_kind = KIND_SW;
                default: o_kind = KIND_ILLEGAL;
                endcase
            `RV_OPG_OP_IMM:
                case (w_f3)
                3'b000: o_kind = KIND_ADDI;
                3'b010: o_kind = KIND_SLTI;
                3'b011: o_kind = KIND_SLTIU;
                3'b100: o_kind = KIND_XORI;
                3'b110: o_kind = KIND_ORI;
                3'b111: o_kind = KIND_ANDI;
                3'b001: o_kind = (w_f7 == `RV_F7_BASE) ? KIND_SLLI : KIND_ILLEGAL;
                3'b101:
                begin
                    if (w_f7 == `RV_F7_BASE)
                        o_kind = KIND_SRLI;
                    else if (w_f7 == `RV_F7_ALT)
                        o_kind = KIND_SRAI;
                end
                default: o_kind = KIND_ILLEGAL;
                endcase
            `RV_OPG_OP:
                case ({w_f7, w_f3})
                {`RV_F7_BASE, 3'b000}: o_kind = KIND_ADD;
                {`RV_F7_ALT,  3'b000}: o_kind = KIND_SUB;
                {`RV_F7_BASE, 3'b001}: o_kind = KIND_SLL;
                {`RV_F7_BASE, 3'b010}: o_kind = KIND_SLT;
                {`RV_F7_BASE, 3'b011}: o_kind = KIND_SLTU;
                {`RV_F7_BASE, 3'b100}: o_kind = KIND_XOR;
                {`RV_F7_BASE, 3'b101}: o_kind = KIND_SRL;
                {`RV_F7_ALT,  3'b101}: o_kind = KIND_SRA;
                {`RV_F7_BASE, 3'b110}: o_kind = KIND_OR;
                {`RV_F7_BASE, 3'b111}: o_kind = KIND_AND;
                default: o_kind = KIND_ILLEGAL;
                endcase
            `RV_OPG_BRANCH:
                case (w_f3)
                3'b000: o_kind = KIND_BEQ;
                3'b001: o_kind = KIND_BNE;
                3'b100: o_kind = KIND_BLT;
                3'b101: o_kind = KIND_BGE;
                3'b110: o_kind = KIND_BLTU;
                3'b111: o_kind = KIND_BGEU;
                default: o_kind = KIND_ILLEGAL;
                endcase
            `RV_OPG_LUI:    o_kind = KIND_LUI;
            `RV_OPG_AUIPC:  o_kind = KIND_AUIPC;
            `RV_OPG_JAL:    o_kind = KIND_JAL;
            `RV_OPG_JALR:   o_kind = (w_f3 == 3'b000) ? KIND_JALR : KIND_ILLEGAL;
            default:        o_kind = KIND_ILLEGAL;
            endcase
        end
    end

endmodule

// ==== hw/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage
    import rv_decode_pkg::*;
#(
    parameter type T = fetch_t
)
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_flush,
    input  logic    i_valid,
    output logic    o_ready,
    input  T        i_data,
    output logic    o_valid,
    input  logic    i_ready,
    output T        o_data
);

    logic   r_full;
    T       r_data;

    // free slot, or the held item leaves this cycle
    assign o_ready = !r_full || i_ready;
    assign o_valid = r_full;
    assign o_data  = r_data;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
            r_full <= 1'b0;
        else if (o_ready)
            r_full <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_ready && i_valid)
            r_data <= i_data;
    end

endmodule

// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define RV_XLEN             32
`define RV_PC_W             30
`define RV_REG_W            5

// opcode groups, bits 6:2 of the opcode
`define RV_OPG_LOAD         5'b00000
`define RV_OPG_OP_IMM       5'b00100
`define RV_OPG_AUIPC        5'b00101
`define RV_OPG_STORE        5'b01000
`define RV_OPG_OP           5'b01100
`define RV_OPG_LUI          5'b01101
`define RV_OPG_BRANCH       5'b11000
`define RV_OPG_JALR         5'b11001
`define RV_OPG_JAL          5'b11011

// legal funct7 values
`define RV_F7_BASE          7'b0000000
`define RV_F7_ALT           7'b0100000

// alu operation codes
`define RV_ALU_ADD          4'd0
`define RV_ALU_SUB          4'd1
`define RV_ALU_XOR          4'd2
`define RV_ALU_OR           4'd3
`define RV_ALU_AND          4'd4
`define RV_ALU_SHL          4'd5
`define RV_ALU_SHR          4'd6
`define RV_ALU_EQ           4'd8
`define RV_ALU_NEQ          4'd9
`define RV_ALU_LTS          4'd10
`define RV_ALU_LTU          4'd11
`define RV_ALU_NLTS         4'd12
`define RV_ALU_NLTU         4'd13

// arithmetic shift flag sits above the op code
`define RV_ALU_ARITH_BIT    4

`endif

// ==== hw/rv_decode_pkg.sv ====
`include "rv_consts.svh"

package rv_decode_pkg;

    typedef enum logic [5:0]
    {
        KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
        KIND_SB, KIND_SH, KIND_SW,
        KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
        KIND_SLLI, KIND_SRLI, KIND_SRAI,
        KIND_ADD, KIND_SUB, KIND_SLL, KIND_SLT, KIND_SLTU,
        KIND_XOR, KIND_SRL, KIND_SRA, KIND_OR, KIND_AND,
        KIND_LUI, KIND_AUIPC,
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
        KIND_JAL, KIND_JALR,
        KIND_ILLEGAL
    } instr_kind_e;

    typedef enum logic [1:0]
    {
        OP1_REG  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_e;

    typedef enum logic
    {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    typedef enum logic [1:0]
    {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } res_src_e;

    typedef struct packed
    {
        logic                           arith;
        logic [`RV_ALU_ARITH_BIT-1:0]   op;
    } alu_ctrl_t;

    typedef struct packed
    {
        logic [`RV_XLEN-1:0]    instr;
        logic [`RV_PC_W-1:0]    pc;
    } fetch_t;

    typedef struct packed
    {
        logic [`RV_REG_W-1:0]   rs1;
        logic [`RV_REG_W-1:0]   rs2;
        logic [`RV_REG_W-1:0]   rd;
        logic [`RV_PC_W-1:0]    pc;
        logic [`RV_XLEN-1:0]    imm;
        logic [2:0]             funct3;
        instr_kind_e            kind;
        op1_sel_e               op1_sel;
        op2_sel_e               op2_sel;
        res_src_e               res_src;
        alu_ctrl_t              alu_ctrl;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   jump;
        logic                   branch;
        logic                   pc_sel;
        logic                   illegal;
    } dec_t;

endpackage

// ==== hw/rv_decode_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_flush,
    input  logic                    i_valid,
    input  logic [`RV_XLEN-1:0]     i_instr,
    input  logic [`RV_PC_W-1:0]     i_pc,
    input  logic                    i_ready,
    output logic                    o_ready,
    output logic                    o_valid,
    output logic [`RV_REG_W-1:0]    o_rs1,
    output logic [`RV_REG_W-1:0]    o_rs2,
    output logic [`RV_REG_W-1:0]    o_rd,
    output logic [`RV_PC_W-1:0]     o_pc,
    output logic [`RV_XLEN-1:0]     o_imm,
    output logic [2:0]              o_funct3,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_jump,
    output logic                    o_branch,
    output logic                    o_pc_sel,
    output logic                    o_illegal,
    output op1_sel_e                o_op1_sel,
    output op2_sel_e                o_op2_sel,
    output res_src_e                o_res_src,
    output alu_ctrl_t               o_alu_ctrl
);

    fetch_t         w_fetch_in;
    fetch_t         w_fetch_q;
    logic           w_fetch_valid;
    logic           w_dec_ready;
    dec_t           w_dec_d;
    dec_t           w_dec_q;
    instr_kind_e    w_kind;
    logic [`RV_XLEN-1:0] w_imm;
    logic           w_reg_write;
    logic           w_mem_read;
    logic           w_mem_write;
    logic           w_jump;
    logic           w_branch;
    logic           w_pc_sel;
    logic           w_illegal;
    op1_sel_e       w_op1_sel;
    op2_sel_e       w_op2_sel;
    res_src_e       w_res_src;
    alu_ctrl_t      w_alu_ctrl;

    assign w_fetch_in = '{instr: i_instr, pc: i_pc};

    pipe_stage #(.T(fetch_t)) u_fetch_slice
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_data     (w_fetch_in),
        .o_valid    (w_fetch_valid),
        .i_ready    (w_dec_ready),
        .o_data     (w_fetch_q)
    );

    op_classifier u_classifier
    (
        .i_instr    (w_fetch_q.instr),
        .o_kind     (w_kind)
    );

    imm_gen u_imm_gen
    (
        .i_instr    (w_fetch_q.instr),
        .i_kind     (w_kind),
        .o_imm      (w_imm)
    );

    ctrl_gen u_ctrl_gen
    (
        .i_kind         (w_kind),
        .o_reg_write    (w_reg_write),
        .o_mem_read     (w_mem_read),
        .o_mem_write    (w_mem_write),
        .o_jump         (w_jump),
        .o_branch       (w_branch),
        .o_pc_sel       (w_pc_sel),
        .o_illegal      (w_illegal),
        .o_op1_sel      (w_op1_sel),
        .o_op2_sel      (w_op2_sel),
        .o_res_src      (w_res_src),
        .o_alu_ctrl     (w_alu_ctrl)
    );

    // register fields come straight from the word
    assign w_dec_d = '{
        rs1:       w_fetch_q.instr[19:15],
        rs2:       w_fetch_q.instr[24:20],
        rd:        w_fetch_q.instr[11:7],
        pc:        w_fetch_q.pc,
        imm:       w_imm,
        funct3:    w_fetch_q.instr[14:12],
        kind:      w_kind,
        op1_sel:   w_op1_sel,
        op2_sel:   w_op2_sel,
        res_src:   w_res_src,
        alu_ctrl:  w_alu_ctrl,
        reg_write: w_reg_write,
        mem_read:  w_mem_read,
        mem_write: w_mem_write,
        jump:      w_jump,
        branch:    w_branch,
        pc_sel:    w_pc_sel,
        illegal:   w_illegal
    };

    pipe_stage #(.T(dec_t)) u_dec_slice
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_valid    (w_fetch_valid),
        .o_ready    (w_dec_ready),
        .i_data     (w_dec_d),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_data     (w_dec_q)
    );

    assign o_rs1       = w_dec_q.rs1;
    assign o_rs2       = w_dec_q.rs2;
    assign o_rd        = w_dec_q.rd;
    assign o_pc        = w_dec_q.pc;
    assign o_imm       = w_dec_q.imm;
    assign o_funct3    = w_dec_q.funct3;
    assign o_reg_write = w_dec_q.reg_write;
    assign o_mem_read  = w_dec_q.mem_read;
    assign o_mem_write = w_dec_q.mem_write;
    assign o_jump      = w_dec_q.jump;
    assign o_branch    = w_dec_q.branch;
    assign o_pc_sel    = w_dec_q.pc_sel;
    assign o_illegal   = w_dec_q.illegal;
    assign o_op1_sel   = w_dec_q.op1_sel;
    assign o_op2_sel   = w_dec_q.op2_sel;
    assign o_res_src   = w_dec_q.res_src;
    assign o_alu_ctrl  = w_dec_q.alu_ctrl;

endmodule

// ==== sim.f ====
+incdir+hw
hw/rv_decode_pkg.sv
hw/pipe_stage.sv
hw/op_classifier.sv
hw/imm_gen.sv
hw/ctrl_gen.sv
hw/rv_decode_top.sv
verification/tb_rv_decode.sv

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_decode
    import rv_decode_pkg::*;
();

    // about ten times the roughly 200 cycles the tests take
    localparam int MAX_CYCLES = 2000;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_flush;
    logic                   i_valid;
    logic [`RV_XLEN-1:0]    i_instr;
    logic [`RV_PC_W-1:0]    i_pc;
    logic                   i_ready;
    logic                   o_ready;
    logic                   o_valid;
    logic [`RV_REG_W-1:0]   o_rs1;
    logic [`RV_REG_W-1:0]   o_rs2;
    logic [`RV_REG_W-1:0]   o_rd;
    logic [`RV_PC_W-1:0]    o_pc;
    logic [`RV_XLEN-1:0]    o_imm;
    logic [2:0]             o_funct3;
    logic                   o_reg_write;
    logic                   o_mem_read;
    logic                   o_mem_write;
    logic                   o_jump;
    logic                   o_branch;
    logic                   o_pc_sel;
    logic                   o_illegal;
    op1_sel_e               o_op1_sel;
    op2_sel_e               o_op2_sel;
    res_src_e               o_res_src;
    alu_ctrl_t              o_alu_ctrl;

    integer seed;
    int     errors;
    int     checks;
    int     start_errors;
    int     cycles;
    string  test_name;

    rv_decode_top UUT
    (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(i_flush), .i_valid(i_valid),
        .i_instr(i_instr), .i_pc(i_pc), .i_ready(i_ready), .o_ready(o_ready),
        .o_valid(o_valid), .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rd), .o_pc(o_pc),
        .o_imm(o_imm), .o_funct3(o_funct3), .o_reg_write(o_reg_write),
        .o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .o_jump(o_jump),
        .o_branch(o_branch), .o_pc_sel(o_pc_sel), .o_illegal(o_illegal),
        .o_op1_sel(o_op1_sel), .o_op2_sel(o_op2_sel), .o_res_src(o_res_src),
        .o_alu_ctrl(o_alu_ctrl)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // instruction encoders
    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OPG_OP, 2'b11};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] opg);
        return {imm, rs1, f3, rd, opg, 2'b11};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPG_STORE, 2'b11};
    endfunction

    function automatic logic [31:0] b_type_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPG_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [4:0] opg);
        return {imm, rd, opg, 2'b11};
    endfunction

    function automatic logic [31:0] j_type_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPG_JAL, 2'b11};
    endfunction

    // addi with rd and immediate both set to n
    function automatic logic [31:0] numbered_word(input int n);
        return i_type_word(12'(n), 5'd0, 3'b000, 5'(n), `RV_OPG_OP_IMM);
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        begin
            checks++;
            if (act !== exp)
            begin
                errors++;
                $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            end
        end
    endtask

    task automatic begin_test(input string name);
        begin
            test_name = name;
            start_errors = errors;
        end
    endtask

    task automatic end_test;
        begin
            $display("%-14s %s", test_name, (errors == start_errors) ? "ok" : "FAILED");
        end
    endtask

    task automatic step;
        begin
            @(posedge i_clk);
            #2;
        end
    endtask

    // offer one word and hold it until the stage takes it
    task automatic send(input logic [31:0] word, input logic [29:0] pc);
        logic accepted;
        begin
            i_valid = 1'b1;
            i_instr = word;
            i_pc = pc;
            accepted = 1'b0;
            while (!accepted)
            begin
                @(negedge i_clk);
                accepted = o_ready;
                step;
            end
            i_valid = 1'b0;
        end
    endtask

    // leaves time at the negedge where the decoded word is visible
    task automatic run_one(input logic [31:0] word, input logic [29:0] pc);
        begin
            send(word, pc);
            @(negedge i_clk);
            while (!o_valid)
                @(negedge i_clk);
        end
    endtask

    task automatic alu_case(input logic [6:0] f7, input logic [2:0] f3, input logic is_imm,
                            input logic [3:0] exp_op, input logic exp_arith);
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        begin
            rnd = $random(seed);
            rd  = rnd[4:0];
            rs1 = rnd[9:5];
            rs2 = rnd[14:10];
            run_one({f7, rs2, rs1, f3, rd, (is_imm ? `RV_OPG_OP_IMM : `RV_OPG_OP), 2'b11},
                    30'h10);
            compare("rs1", 32'(rs1), 32'(o_rs1));
            compare("rs2", 32'(rs2), 32'(o_rs2));
            compare("rd", 32'(rd), 32'(o_rd));
            compare("funct3", 32'(f3), 32'(o_funct3));
            compare("alu op", 32'(exp_op), 32'(o_alu_ctrl.op));
            compare("arith", 32'(exp_arith), 32'(o_alu_ctrl.arith));
            compare("op2_sel", 32'(is_imm ? OP2_IMM : OP2_REG), 32'(o_op2_sel));
            compare("reg_write", 32'd1, 32'(o_reg_write));
            step;
        end
    endtask

    task automatic imm_case(input logic [31:0] word, input logic [31:0] exp_imm);
        begin
            run_one(word, 30'h20);
            compare("imm", exp_imm, o_imm);
            step;
        end
    endtask

    task automatic ctrl_case(input logic [31:0] word, input logic [29:0] pc,
                             input logic mr, input logic mw, input logic br,
                             input logic jp, input logic ps, input res_src_e res,
                             input op1_sel_e op1);
        begin
            run_one(word, pc);
            compare("mem_read", 32'(mr), 32'(o_mem_read));
            compare("mem_write", 32'(mw), 32'(o_mem_write));
            compare("branch", 32'(br), 32'(o_branch));
            compare("jump", 32'(jp), 32'(o_jump));
            compare("pc_sel", 32'(ps), 32'(o_pc_sel));
            compare("res_src", 32'(res), 32'(o_res_src));
            compare("op1_sel", 32'(op1), 32'(o_op1_sel));
            compare("pc", 32'(pc), 32'(o_pc));
            step;
        end
    endtask

    task automatic illegal_case(input logic [31:0] word);
        begin
            run_one(word, 30'h30);
            compare("illegal", 32'd1, 32'(o_illegal));
            compare("reg_write", 32'd0, 32'(o_reg_write));
            compare("mem_read", 32'd0, 32'(o_mem_read));
            compare("mem_write", 32'd0, 32'(o_mem_write));
            compare("jump", 32'd0, 32'(o_jump));
            compare("branch", 32'd0, 32'(o_branch));
            step;
        end
    endtask

    task automatic alu_op_decode;
        begin
            begin_test("alu ops");
            alu_case(`RV_F7_BASE, 3'b000, 1'b0, `RV_ALU_ADD, 1'b0);
            alu_case(`RV_F7_ALT,  3'b000, 1'b0, `RV_ALU_SUB, 1'b0);
            alu_case(`RV_F7_BASE, 3'b001, 1'b0, `RV_ALU_SHL, 1'b0);
            alu_case(`RV_F7_BASE, 3'b010, 1'b0, `RV_ALU_LTS, 1'b0);
            alu_case(`RV_F7_BASE, 3'b011, 1'b0, `RV_ALU_LTU, 1'b0);
            alu_case(`RV_F7_BASE, 3'b100, 1'b0, `RV_ALU_XOR, 1'b0);
            alu_case(`RV_F7_BASE, 3'b101, 1'b0, `RV_ALU_SHR, 1'b0);
            alu_case(`RV_F7_ALT,  3'b101, 1'b0, `RV_ALU_SHR, 1'b1);
            alu_case(`RV_F7_BASE, 3'b110, 1'b0, `RV_ALU_OR,  1'b0);
            alu_case(`RV_F7_BASE, 3'b111, 1'b0, `RV_ALU_AND, 1'b0);
            alu_case(`RV_F7_BASE, 3'b000, 1'b1, `RV_ALU_ADD, 1'b0);
            alu_case(`RV_F7_BASE, 3'b010, 1'b1, `RV_ALU_LTS, 1'b0);
            alu_case(`RV_F7_BASE, 3'b011, 1'b1, `RV_ALU_LTU, 1'b0);
            alu_case(`RV_F7_BASE, 3'b100, 1'b1, `RV_ALU_XOR, 1'b0);
            alu_case(`RV_F7_BASE, 3'b110, 1'b1, `RV_ALU_OR,  1'b0);
            alu_case(`RV_F7_BASE, 3'b111, 1'b1, `RV_ALU_AND, 1'b0);
            alu_case(`RV_F7_BASE, 3'b001, 1'b1, `RV_ALU_SHL, 1'b0);
            alu_case(`RV_F7_BASE, 3'b101, 1'b1, `RV_ALU_SHR, 1'b0);
            alu_case(`RV_F7_ALT,  3'b101, 1'b1, `RV_ALU_SHR, 1'b1);
            end_test;
        end
    endtask

    task automatic immediate_formats;
        begin
            begin_test("immediates");
            imm_case(i_type_word(12'hfff, 5'd1, 3'b010, 5'd2, `RV_OPG_LOAD), 32'hffff_ffff);
            imm_case(i_type_word(12'h5a3, 5'd1, 3'b010, 5'd2, `RV_OPG_LOAD), 32'h0000_05a3);
            imm_case(s_type_word(12'hfff, 5'd3, 5'd4, 3'b010), 32'hffff_ffff);
            imm_case(s_type_word(12'h823, 5'd3, 5'd4, 3'b010), 32'hffff_f823);
            imm_case(b_type_word(13'h1ffe, 5'd5, 5'd6, 3'b000), 32'hffff_fffe);
            imm_case(b_type_word(13'h0aa4, 5'd5, 5'd6, 3'b000), 32'h0000_0aa4);
            imm_case(u_type_word(20'hfffff, 5'd7, `RV_OPG_LUI), 32'hffff_f000);
            imm_case(u_type_word(20'h12345, 5'd7, `RV_OPG_LUI), 32'h1234_5000);
            imm_case(j_type_word(21'h1ffffe, 5'd8), 32'hffff_fffe);
            imm_case(j_type_word(21'h1abcde, 5'd8), 32'hfffa_bcde);
            end_test;
        end
    endtask

    task automatic control_flags;
        begin
            begin_test("controls");
            ctrl_case(i_type_word(12'h010, 5'd2, 3'b010, 5'd3, `RV_OPG_LOAD), 30'h100,
                      1, 0, 0, 0, 0, RES_MEM, OP1_REG);
            ctrl_case(s_type_word(12'h004, 5'd4, 5'd5, 3'b000), 30'h101,
                      0, 1, 0, 0, 0, RES_ALU, OP1_REG);
            ctrl_case(b_type_word(13'h0010, 5'd6, 5'd7, 3'b001), 30'h102,
                      0, 0, 1, 0, 0, RES_ALU, OP1_REG);
            ctrl_case(j_type_word(21'h000100, 5'd1), 30'h103,
                      0, 0, 0, 1, 0, RES_PC4, OP1_PC);
            ctrl_case(i_type_word(12'h008, 5'd9, 3'b000, 5'd1, `RV_OPG_JALR), 30'h104,
                      0, 0, 0, 1, 1, RES_PC4, OP1_REG);
            ctrl_case(u_type_word(20'h00abc, 5'd10, `RV_OPG_AUIPC), 30'h105,
                      0, 0, 0, 0, 0, RES_ALU, OP1_PC);
            ctrl_case(u_type_word(20'h00abc, 5'd11, `RV_OPG_LUI), 30'h106,
                      0, 0, 0, 0, 0, RES_ALU, OP1_ZERO);
            end_test;
        end
    endtask

    task automatic illegal_words;
        begin
            begin_test("illegal");
            // fence, ecall, csrrw x1 mstatus x2, c.li, add with funct7 of 1
            illegal_case(32'h0000_000f);
            illegal_case(32'h0000_0073);
            illegal_case(32'h3001_1073);
            illegal_case(32'h0000_4501);
            illegal_case(r_type_word(7'd1, 5'd2, 5'd1, 3'b000, 5'd3));
            end_test;
        end
    endtask

    task automatic backpressure_order;
        int   sent;
        int   nxt;
        logic stalled;
        logic take;
        begin
            begin_test("backpressure");
            i_ready = 1'b0;
            sent = 0;
            stalled = 1'b0;
            i_valid = 1'b1;
            i_instr = numbered_word(1);
            i_pc = 30'd1;
            while (!stalled)
            begin
                @(negedge i_clk);
                if (o_ready)
                begin
                    step;
                    sent++;
                    i_instr = numbered_word(sent + 1);
                    i_pc = 30'(sent + 1);
                end
                else
                    stalled = 1'b1;
            end
            compare("taken before stall", 32'd2, 32'(sent));
            repeat (2)
            begin
                @(posedge i_clk);
                @(negedge i_clk);
                compare("ready while stalled", 32'd0, 32'(o_ready));
                compare("valid while stalled", 32'd1, 32'(o_valid));
                compare("rd while stalled", 32'd1, 32'(o_rd));
            end
            step;
            i_ready = 1'b1;
            nxt = 1;
            while (nxt <= 4)
            begin
                @(negedge i_clk);
                if (o_valid)
                begin
                    compare("rd in order", 32'(nxt), 32'(o_rd));
                    nxt++;
                end
                take = i_valid && o_ready;
                step;
                if (take)
                begin
                    sent++;
                    if (sent < 4)
                    begin
                        i_instr = numbered_word(sent + 1);
                        i_pc = 30'(sent + 1);
                    end
                    else
                        i_valid = 1'b0;
                end
            end
            @(negedge i_clk);
            compare("valid after drain", 32'd0, 32'(o_valid));
            step;
            end_test;
        end
    endtask

    task automatic flush_recovery;
        begin
            begin_test("flush");
            i_ready = 1'b0;
            send(numbered_word(7), 30'h40);
            send(numbered_word(8), 30'h41);
            @(negedge i_clk);
            compare("ready when full", 32'd0, 32'(o_ready));
            step;
            i_flush = 1'b1;
            step;
            i_flush = 1'b0;
            @(negedge i_clk);
            compare("valid after flush", 32'd0, 32'(o_valid));
            compare("ready after flush", 32'd1, 32'(o_ready));
            step;
            i_ready = 1'b1;
            run_one(r_type_word(`RV_F7_BASE, 5'd5, 5'd6, 3'b000, 5'd9), 30'h42);
            compare("rd", 32'd9, 32'(o_rd));
            compare("rs1", 32'd6, 32'(o_rs1));
            compare("rs2", 32'd5, 32'(o_rs2));
            compare("pc", 32'h42, 32'(o_pc));
            compare("illegal", 32'd0, 32'(o_illegal));
            step;
            @(negedge i_clk);
            compare("valid after drain", 32'd0, 32'(o_valid));
            end_test;
        end
    endtask

    initial
    begin
        seed = 32'h72bf_1806;
        errors = 0;
        checks = 0;
        i_rst_n = 1'b0;
        i_flush = 1'b0;
        i_valid = 1'b0;
        i_instr = '0;
        i_pc = '0;
        i_ready = 1'b1;
        repeat (3) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        begin_test("reset");
        @(negedge i_clk);
        compare("valid", 32'd0, 32'(o_valid));
        compare("ready", 32'd1, 32'(o_ready));
        end_test;
        step;
        alu_op_decode;
        immediate_formats;
        control_flags;
        illegal_words;
        backpressure_order;
        flush_recovery;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
